// File: noc_pkg.sv
package noc_pkg;

    // Link geometry
    localparam int payload_width = 128;
    // Payload in the upper half, complement guard in the lower half
    localparam int link_width    = 2 * payload_width;
    localparam int dest_width    = 4;
    localparam int gap_width     = 8;

    // Generator payload word
    typedef logic [payload_width-1:0] payload_t;

    // Link word carried by the router
    typedef logic [link_width-1:0] link_data_t;

    // Destination, kept in 1..15 by the generator
    typedef logic [dest_width-1:0] dest_t;

    // Source generator index
    typedef logic [0:0] src_t;

    // Gap counter
    typedef logic [gap_width-1:0] gap_count_t;

    // Idle cycles before each offered word
    localparam int gap_cycles = 25;

    // Destination LFSR seeds, must be non-zero
    localparam dest_t dest_seed_0 = 4'b0001;
    localparam dest_t dest_seed_1 = 4'b1011;

    // Payload LFSR seeds, must be non-zero
    localparam payload_t data_seed_0 = 128'hA5A5_A5A5_A5A5_A5A5_A5A5_A5A5_A5A5_A5A5;
    localparam payload_t data_seed_1 = 128'h0F1E_2D3C_4B5A_6978_8796_A5B4_C3D2_E1F0;

    // Router ports, inputs and outputs alike
    localparam int num_ports = 2;

endpackage

// File: traffic_gen.sv
`timescale 1ns/1ps

module traffic_gen #(
    parameter noc_pkg::dest_t    dest_seed = noc_pkg::dest_seed_0,
    parameter noc_pkg::payload_t data_seed = noc_pkg::data_seed_0
) (
    input  logic                 clk,
    input  logic                 reset,
    // Stream towards the router
    output logic                 tvalid,
    output noc_pkg::link_data_t  tdata,
    output noc_pkg::dest_t       tdest,
    input  logic                 tready
);

    // Gap counter and LFSR state
    noc_pkg::gap_count_t gap_cnt;
    noc_pkg::dest_t      lfsr_dest;
    noc_pkg::payload_t   lfsr_data;

    // Next LFSR values
    noc_pkg::dest_t      dest_next;
    noc_pkg::payload_t   data_next;

    // Word handed over this cycle
    logic                accept;

    assign accept = tvalid && tready;

    // Destination LFSR, x^4 + x^3 + 1
    assign dest_next = {lfsr_dest[2:0], lfsr_dest[3] ^ lfsr_dest[2]};

    // Payload LFSR, x^128 + x^126 + x^101 + x^99 + 1
    assign data_next = {lfsr_data[126:0],
                        lfsr_data[127] ^ lfsr_data[125] ^ lfsr_data[100] ^ lfsr_data[98]};

    // Gap phase, then offer phase until the router takes the word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            gap_cnt <= '0;
            tvalid  <= 1'b0;
        end else begin
            if (tvalid) begin
                // Hold the offer until accepted
                if (tready) begin
                    gap_cnt <= '0;
                    tvalid  <= 1'b0;
                end
            end else if (gap_cnt == noc_pkg::gap_count_t'(noc_pkg::gap_cycles - 1)) begin
                // Gap done, raise valid on this edge
                tvalid <= 1'b1;
            end else begin
                gap_cnt <= gap_cnt + noc_pkg::gap_count_t'(1);
            end
        end
    end

    // LFSRs step only on accepted words
    // so the sequence does not depend on back-pressure
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr_dest <= dest_seed;
            lfsr_data <= data_seed;
        end else if (accept) begin
            lfsr_dest <= dest_next;
            lfsr_data <= data_next;
        end
    end

    // Zero state never occurs with a non-zero seed, map it to 1 anyway
    assign tdest = (lfsr_dest == '0) ? noc_pkg::dest_t'(1) : lfsr_dest;

    // Payload on top, complement guard below
    assign tdata = {lfsr_data, ~lfsr_data};

endmodule

// File: stream_router.sv
`timescale 1ns/1ps

module stream_router (
    input  logic                 clk,
    input  logic                 reset,
    // Input 0
    input  logic                 in_valid_0,
    input  noc_pkg::link_data_t  in_data_0,
    input  noc_pkg::dest_t       in_dest_0,
    output logic                 in_ready_0,
    // Input 1
    input  logic                 in_valid_1,
    input  noc_pkg::link_data_t  in_data_1,
    input  noc_pkg::dest_t       in_dest_1,
    output logic                 in_ready_1,
    // Output 0
    output logic                 out_valid_0,
    output noc_pkg::link_data_t  out_data_0,
    output noc_pkg::dest_t       out_dest_0,
    output noc_pkg::src_t        out_src_0,
    input  logic                 out_ready_0,
    // Output 1
    output logic                 out_valid_1,
    output noc_pkg::link_data_t  out_data_1,
    output noc_pkg::dest_t       out_dest_1,
    output noc_pkg::src_t        out_src_1,
    input  logic                 out_ready_1
);

    localparam int np = noc_pkg::num_ports;

    // Inputs gathered into arrays, indexed by input
    logic                in_valid [np];
    noc_pkg::link_data_t in_data  [np];
    noc_pkg::dest_t      in_dest  [np];
    logic                in_ready [np];

    // Output side, indexed by output
    logic                out_ready [np];
    logic                valid_q   [np];
    noc_pkg::link_data_t data_q    [np];
    noc_pkg::dest_t      dest_q    [np];
    noc_pkg::src_t       src_q     [np];

    // Request and grant, [output][input]
    logic [np-1:0]       req   [np];
    logic [np-1:0]       grant [np];

    assign in_valid[0] = in_valid_0;
    assign in_valid[1] = in_valid_1;
    assign in_data[0]  = in_data_0;
    assign in_data[1]  = in_data_1;
    assign in_dest[0]  = in_dest_0;
    assign in_dest[1]  = in_dest_1;
    assign in_ready_0  = in_ready[0];
    assign in_ready_1  = in_ready[1];

    assign out_ready[0] = out_ready_0;
    assign out_ready[1] = out_ready_1;

    assign out_valid_0 = valid_q[0];
    assign out_data_0  = data_q[0];
    assign out_dest_0  = dest_q[0];
    assign out_src_0   = src_q[0];
    assign out_valid_1 = valid_q[1];
    assign out_data_1  = data_q[1];
    assign out_dest_1  = dest_q[1];
    assign out_src_1   = src_q[1];

    // Destination bit 0 picks the output
    always_comb begin
        for (int j = 0; j < np; j++) begin
            for (int i = 0; i < np; i++) begin
                req[j][i] = in_valid[i] && (in_dest[i][0] == j[0]);
            end
        end
    end

    // An input requests one output only, so its ready is any grant
    always_comb begin
        for (int i = 0; i < np; i++) begin
            in_ready[i] = 1'b0;
            for (int j = 0; j < np; j++) begin
                in_ready[i] = in_ready[i] | grant[j][i];
            end
        end
    end

    for (genvar j = 0; j < np; j++) begin : g_port
        // Last input granted on this port
        noc_pkg::src_t last_q;
        noc_pkg::src_t win_sel;
        logic          can_load;
        logic          load;

        // Register free, or draining this cycle
        assign can_load = !valid_q[j] || out_ready[j];

        // On a tie the input that did not win last time wins
        always_comb begin
            if (req[j][0] && req[j][1]) begin
                win_sel = ~last_q;
            end else if (req[j][1]) begin
                win_sel = noc_pkg::src_t'(1);
            end else begin
                win_sel = noc_pkg::src_t'(0);
            end
        end

        assign load = (|req[j]) && can_load;

        // Ready goes only to the winner, the loser waits
        always_comb begin
            for (int i = 0; i < np; i++) begin
                grant[j][i] = load && (win_sel == i[0]) && req[j][i];
            end
        end

        // Valid flag and round-robin pointer
        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                valid_q[j] <= 1'b0;
                // Input 0 gets first pick
                last_q     <= noc_pkg::src_t'(1);
            end else if (load) begin
                valid_q[j] <= 1'b1;
                last_q     <= win_sel;
            end else if (out_ready[j]) begin
                valid_q[j] <= 1'b0;
            end
        end

        // Payload of the output stage
        always_ff @(posedge clk) begin
            if (load) begin
                data_q[j] <= in_data[win_sel];
                dest_q[j] <= in_dest[win_sel];
                src_q[j]  <= win_sel;
            end
        end
    end

endmodule

// File: stream_endpoint.sv
`timescale 1ns/1ps

module stream_endpoint (
    input  logic                 clk,
    input  logic                 reset,
    // Link from the router
    input  logic                 in_valid,
    input  noc_pkg::link_data_t  in_data,
    input  noc_pkg::dest_t       in_dest,
    input  noc_pkg::src_t        in_src,
    output logic                 in_ready,
    // Unpacked word to the outside
    output logic                 out_valid,
    output noc_pkg::payload_t    out_payload,
    output noc_pkg::dest_t       out_dest,
    output noc_pkg::src_t        out_src,
    input  logic                 out_ready,
    output logic                 link_error
);

    // Link word halves
    noc_pkg::payload_t upper;
    noc_pkg::payload_t guard;

    // Guard mismatch on the incoming word
    logic              guard_bad;
    logic              accept;

    assign upper = in_data[noc_pkg::link_width-1:noc_pkg::payload_width];
    assign guard = in_data[noc_pkg::payload_width-1:0];

    // Lower half must be the complement of the upper half
    assign guard_bad = (guard != ~upper);

    // Same full-rate rule as the router stage
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    // Valid flag and sticky error
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid  <= 1'b0;
            link_error <= 1'b0;
        end else begin
            if (accept) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            // Stays set until reset
            if (accept && guard_bad) begin
                link_error <= 1'b1;
            end
        end
    end

    // Payload register, upper half only
    always_ff @(posedge clk) begin
        if (accept) begin
            out_payload <= upper;
            out_dest    <= in_dest;
            out_src     <= in_src;
        end
    end

endmodule

// File: noc_top.sv
`timescale 1ns/1ps

module noc_top (
    input  logic                 clk,
    input  logic                 reset,
    // Port 0
    output logic                 out_valid_0,
    output noc_pkg::payload_t    out_payload_0,
    output noc_pkg::dest_t       out_dest_0,
    output noc_pkg::src_t        out_src_0,
    input  logic                 out_ready_0,
    output logic                 link_error_0,
    // Port 1
    output logic                 out_valid_1,
    output noc_pkg::payload_t    out_payload_1,
    output noc_pkg::dest_t       out_dest_1,
    output noc_pkg::src_t        out_src_1,
    input  logic                 out_ready_1,
    output logic                 link_error_1
);

    // Generator to router
    logic                gen_valid_0;
    noc_pkg::link_data_t gen_data_0;
    noc_pkg::dest_t      gen_dest_0;
    logic                gen_ready_0;
    logic                gen_valid_1;
    noc_pkg::link_data_t gen_data_1;
    noc_pkg::dest_t      gen_dest_1;
    logic                gen_ready_1;

    // Router to endpoints
    logic                rt_valid_0;
    noc_pkg::link_data_t rt_data_0;
    noc_pkg::dest_t      rt_dest_0;
    noc_pkg::src_t       rt_src_0;
    logic                rt_ready_0;
    logic                rt_valid_1;
    noc_pkg::link_data_t rt_data_1;
    noc_pkg::dest_t      rt_dest_1;
    noc_pkg::src_t       rt_src_1;
    logic                rt_ready_1;

    // Generators with distinct seeds
    traffic_gen #(
        .dest_seed (noc_pkg::dest_seed_0),
        .data_seed (noc_pkg::data_seed_0)
    ) gen_0 (
        .clk    (clk),
        .reset  (reset),
        .tvalid (gen_valid_0),
        .tdata  (gen_data_0),
        .tdest  (gen_dest_0),
        .tready (gen_ready_0)
    );

    traffic_gen #(
        .dest_seed (noc_pkg::dest_seed_1),
        .data_seed (noc_pkg::data_seed_1)
    ) gen_1 (
        .clk    (clk),
        .reset  (reset),
        .tvalid (gen_valid_1),
        .tdata  (gen_data_1),
        .tdest  (gen_dest_1),
        .tready (gen_ready_1)
    );

    stream_router u_router (
        .clk         (clk),
        .reset       (reset),
        .in_valid_0  (gen_valid_0),
        .in_data_0   (gen_data_0),
        .in_dest_0   (gen_dest_0),
        .in_ready_0  (gen_ready_0),
        .in_valid_1  (gen_valid_1),
        .in_data_1   (gen_data_1),
        .in_dest_1   (gen_dest_1),
        .in_ready_1  (gen_ready_1),
        .out_valid_0 (rt_valid_0),
        .out_data_0  (rt_data_0),
        .out_dest_0  (rt_dest_0),
        .out_src_0   (rt_src_0),
        .out_ready_0 (rt_ready_0),
        .out_valid_1 (rt_valid_1),
        .out_data_1  (rt_data_1),
        .out_dest_1  (rt_dest_1),
        .out_src_1   (rt_src_1),
        .out_ready_1 (rt_ready_1)
    );

    stream_endpoint ep_0 (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (rt_valid_0),
        .in_data     (rt_data_0),
        .in_dest     (rt_dest_0),
        .in_src      (rt_src_0),
        .in_ready    (rt_ready_0),
        .out_valid   (out_valid_0),
        .out_payload (out_payload_0),
        .out_dest    (out_dest_0),
        .out_src     (out_src_0),
        .out_ready   (out_ready_0),
        .link_error  (link_error_0)
    );

    stream_endpoint ep_1 (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (rt_valid_1),
        .in_data     (rt_data_1),
        .in_dest     (rt_dest_1),
        .in_src      (rt_src_1),
        .in_ready    (rt_ready_1),
        .out_valid   (out_valid_1),
        .out_payload (out_payload_1),
        .out_dest    (out_dest_1),
        .out_src     (out_src_1),
        .out_ready   (out_ready_1),
        .link_error  (link_error_1)
    );

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
    parameter int words_per_src = 24,
    parameter int surplus       = 8
) (
    input  logic              clk,
    input  logic              reset,
    // Port 0 of the DUT
    input  logic              out_valid_0,
    input  noc_pkg::payload_t out_payload_0,
    input  noc_pkg::dest_t    out_dest_0,
    input  noc_pkg::src_t     out_src_0,
    input  logic              out_ready_0,
    input  logic              link_error_0,
    // Port 1 of the DUT
    input  logic              out_valid_1,
    input  noc_pkg::payload_t out_payload_1,
    input  noc_pkg::dest_t    out_dest_1,
    input  noc_pkg::src_t     out_src_1,
    input  logic              out_ready_1,
    input  logic              link_error_1,
    // Run status for the testbench top
    output logic              done,
    output int                error_count
);

    // Predicted words per source with a tail that absorbs late arrivals
    localparam int depth       = words_per_src + surplus;
    // Cycles after reset during which outputs must stay quiet
    localparam int reset_watch = 4;

    // Expected words in queue port * 2 + source
    noc_pkg::payload_t exp_payload [4][depth];
    noc_pkg::dest_t    exp_dest    [4][depth];
    int                exp_idx     [4][depth];
    int                wr_ptr      [4];
    int                rd_ptr      [4];

    // Error count of checks 1 to 5
    int                test_err [1:5];
    // Checked words taken per source
    int                seen [2];
    int                compared;
    int                post_reset;
    // Clock edges seen while reset is high
    int                reset_edges;
    logic              link_err_seen;

    // Destination LFSR x^4 + x^3 + 1
    function automatic noc_pkg::dest_t step_dest(input noc_pkg::dest_t d);
        logic fb;
        fb = d[3] ^ d[2];
        return {d[2:0], fb};
    endfunction

    // Payload LFSR x^128 + x^126 + x^101 + x^99 + 1
    function automatic noc_pkg::payload_t step_data(input noc_pkg::payload_t v);
        logic fb;
        fb = v[127] ^ v[125] ^ v[100] ^ v[98];
        return {v[126:0], fb};
    endfunction

    // Reference generator that sorts its word sequence into the per-port queues
    function automatic void predict_source(input int src, input noc_pkg::dest_t dseed,
                                           input noc_pkg::payload_t pseed);
        noc_pkg::dest_t    d;
        noc_pkg::payload_t v;
        noc_pkg::dest_t    dest;
        int                k;
        d = dseed;
        v = pseed;
        for (int n = 0; n < depth; n++) begin
            // LFSR state 0 would be sent as 1
            dest = (d == 4'd0) ? 4'd1 : d;
            k = 2 * int'(dest[0]) + src;
            exp_payload[k][wr_ptr[k]] = v;
            exp_dest[k][wr_ptr[k]]    = dest;
            exp_idx[k][wr_ptr[k]]     = n;
            wr_ptr[k]++;
            // Steps once per accepted word
            d = step_dest(d);
            v = step_data(v);
        end
    endfunction

    task automatic report_test(input int num, input string name);
        if (test_err[num] == 0) begin
            $display("check %0d %s: ok", num, name);
        end else begin
            $display("check %0d %s: FAIL with %0d errors", num, name, test_err[num]);
        end
    endtask

    // Compare one transfer with the front of its queue
    task automatic check_word(input int port, input noc_pkg::payload_t payload,
                              input noc_pkg::dest_t dest, input noc_pkg::src_t src);
        int s;
        int k;
        s = int'(src);
        k = 2 * port + s;
        // Routing by dest bit 0 and dest never 0
        if (dest[0] != port[0] || dest == 4'd0) begin
            $display("Fail %0t: port %0d delivered dest %0d", $time, port, dest);
            test_err[4]++;
        end
        if (rd_ptr[k] == wr_ptr[k]) begin
            $display("Unexpected extra word from source %0d at port %0d at time %0t",
                     s, port, $time);
            test_err[5]++;
        end else begin
            if (payload !== exp_payload[k][rd_ptr[k]] || dest !== exp_dest[k][rd_ptr[k]]) begin
                $display("Fail %0t: port %0d src %0d word %0d got %h/%0d expected %h/%0d",
                         $time, port, s, exp_idx[k][rd_ptr[k]], payload, dest,
                         exp_payload[k][rd_ptr[k]], exp_dest[k][rd_ptr[k]]);
                // Check 2 covers source 0 and check 3 source 1
                test_err[2 + s]++;
            end
            if (exp_idx[k][rd_ptr[k]] < words_per_src) begin
                seen[s]++;
            end
            rd_ptr[k]++;
            compared++;
        end
    endtask

    task automatic finish_run();
        int ok;
        int total;
        ok = 0;
        total = 0;
        report_test(2, "source 0 sequence");
        report_test(3, "source 1 sequence");
        report_test(4, "port and dest range");
        report_test(5, "no loss and clean link");
        for (int n = 1; n <= 5; n++) begin
            total = total + test_err[n];
            if (test_err[n] == 0) begin
                ok++;
            end
        end
        $display("Summary: %0d of 5 checks ok, %0d words compared, %0d errors",
                 ok, compared, total);
        error_count = total;
        done <= 1'b1;
    endtask

    initial begin
        done          = 1'b0;
        error_count   = 0;
        compared      = 0;
        post_reset    = 0;
        reset_edges   = 0;
        link_err_seen = 1'b0;
        for (int n = 1; n <= 5; n++) begin
            test_err[n] = 0;
        end
        for (int k = 0; k < 4; k++) begin
            wr_ptr[k] = 0;
            rd_ptr[k] = 0;
        end
        seen[0] = 0;
        seen[1] = 0;
        predict_source(0, noc_pkg::dest_seed_0, noc_pkg::data_seed_0);
        predict_source(1, noc_pkg::dest_seed_1, noc_pkg::data_seed_1);
    end

    // Sampled on the edge before the testbench updates ready
    always @(posedge clk) begin
        if (reset || post_reset < reset_watch) begin
            // Quiet outputs once reset has been clocked and in the first cycles after it
            if ((!reset || reset_edges > 0) &&
                (out_valid_0 !== 1'b0 || out_valid_1 !== 1'b0 ||
                 link_error_0 !== 1'b0 || link_error_1 !== 1'b0)) begin
                $display("Fail %0t: valid or link_error not low around reset", $time);
                test_err[1]++;
            end
            if (reset) begin
                reset_edges++;
            end else begin
                post_reset++;
                if (post_reset == reset_watch) begin
                    report_test(1, "reset state");
                end
            end
        end else if (!done) begin
            if (out_valid_0 && out_ready_0) begin
                check_word(0, out_payload_0, out_dest_0, out_src_0);
            end
            if (out_valid_1 && out_ready_1) begin
                check_word(1, out_payload_1, out_dest_1, out_src_1);
            end
            // Sticky flag counted once
            if ((link_error_0 || link_error_1) && !link_err_seen) begin
                $display("Link error flag went high at time %0t", $time);
                link_err_seen = 1'b1;
                test_err[5]++;
            end
            if (seen[0] == words_per_src && seen[1] == words_per_src) begin
                finish_run();
            end
        end
    end

endmodule

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top;

    // Checked words per generator
    localparam int words_per_src  = 24;
    localparam int reset_cycles   = 16;
    // Cycles of constant ready before the random phase
    localparam int steady_cycles  = 320;
    localparam int total_words    = 2 * words_per_src;
    localparam int timeout_cycles = total_words * (noc_pkg::gap_cycles + 2) * 4;

    logic              clk;
    logic              reset;
    logic              out_ready_0;
    logic              out_ready_1;
    logic              out_valid_0;
    logic              out_valid_1;
    noc_pkg::payload_t out_payload_0;
    noc_pkg::payload_t out_payload_1;
    noc_pkg::dest_t    out_dest_0;
    noc_pkg::dest_t    out_dest_1;
    noc_pkg::src_t     out_src_0;
    noc_pkg::src_t     out_src_1;
    logic              link_error_0;
    logic              link_error_1;

    logic              done;
    int                error_count;
    logic [31:0]       lcg_state;
    int                cycle;

    // 40 ns period
    always #20 clk = ~clk;

    // 31-bit LCG
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return (s * 32'd1103515245 + 32'd12345) & 32'h7fff_ffff;
    endfunction

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        out_ready_0 = 1'b0;
        out_ready_1 = 1'b0;
        lcg_state   = 32'd91;
        cycle       = 0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

    // Ready always high first, then random with about half duty
    always @(posedge clk) begin
        if (!reset) begin
            cycle <= cycle + 1;
            if (cycle < steady_cycles) begin
                out_ready_0 <= 1'b1;
                out_ready_1 <= 1'b1;
            end else begin
                lcg_state   <= lcg_next(lcg_state);
                out_ready_0 <= lcg_state[16];
                out_ready_1 <= lcg_state[24];
            end
        end
    end

    noc_top DUT (
        .clk           (clk),
        .reset         (reset),
        .out_valid_0   (out_valid_0),
        .out_payload_0 (out_payload_0),
        .out_dest_0    (out_dest_0),
        .out_src_0     (out_src_0),
        .out_ready_0   (out_ready_0),
        .link_error_0  (link_error_0),
        .out_valid_1   (out_valid_1),
        .out_payload_1 (out_payload_1),
        .out_dest_1    (out_dest_1),
        .out_src_1     (out_src_1),
        .out_ready_1   (out_ready_1),
        .link_error_1  (link_error_1)
    );

    tb_checker #(
        .words_per_src (words_per_src)
    ) u_checker (
        .clk           (clk),
        .reset         (reset),
        .out_valid_0   (out_valid_0),
        .out_payload_0 (out_payload_0),
        .out_dest_0    (out_dest_0),
        .out_src_0     (out_src_0),
        .out_ready_0   (out_ready_0),
        .link_error_0  (link_error_0),
        .out_valid_1   (out_valid_1),
        .out_payload_1 (out_payload_1),
        .out_dest_1    (out_dest_1),
        .out_src_1     (out_src_1),
        .out_ready_1   (out_ready_1),
        .link_error_1  (link_error_1),
        .done          (done),
        .error_count   (error_count)
    );

    // Normal end once the checker has seen every word
    initial begin
        wait (done === 1'b1);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the word count and the generator gap
    initial begin
        repeat (reset_cycles + timeout_cycles) @(posedge clk);
        $display("Run timed out after %0d cycles with words still missing", timeout_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

// File: files.f
noc_pkg.sv
traffic_gen.sv
stream_router.sv
stream_endpoint.sv
noc_top.sv
tb_checker.sv
tb_top.sv
